// File: src/tx_ctrl_pkg.sv
// tx control package, shared constants, state encoding and the reply word layout
package tx_ctrl_pkg;

  // timebase of this build
  localparam int NUM_CLK_PER_US = 10;
  localparam int COUNT_SCALE    = 4;

  // ack and cts always go out at 6 Mb/s, 14 bytes
  localparam int          ACK_N_SYM   = 6;
  localparam logic [11:0] ACK_SIG_LEN = 12'd14;
  localparam logic [15:0] RTS_SIG_LEN = 16'd20;
  localparam logic [3:0]  RATE_6M     = 4'b1011;

  // frame control type
  localparam logic [1:0] FC_TYPE_MGMT = 2'b00;
  localparam logic [1:0] FC_TYPE_CTRL = 2'b01;
  localparam logic [1:0] FC_TYPE_DATA = 2'b10;

  // frame control subtype
  localparam logic [3:0] FC_SUB_ACK       = 4'b1101;
  localparam logic [3:0] FC_SUB_CTS       = 4'b1100;
  localparam logic [3:0] FC_SUB_RTS       = 4'b1011;
  localparam logic [3:0] FC_SUB_BAR       = 4'b1000;
  localparam logic [3:0] FC_SUB_BA        = 4'b1001;
  localparam logic [3:0] FC_SUB_PSPOLL    = 4'b1010;
  // reserved mgmt subtype, never answered
  localparam logic [3:0] FC_SUB_MGMT_EXCL = 4'b1110;

  // kind of reply owed to the last received frame
  localparam logic [1:0] CLS_NONE     = 2'd0;
  localparam logic [1:0] CLS_ACK_ZERO = 2'd1;
  localparam logic [1:0] CLS_ACK_DUR  = 2'd2;
  localparam logic [1:0] CLS_CTS      = 2'd3;

  // tx bram word addresses of the reply
  localparam int                     BRAM_ADDR_W = 10;
  localparam logic [BRAM_ADDR_W-1:0] ADDR_SIG    = 'd0;
  localparam logic [BRAM_ADDR_W-1:0] ADDR_HDR    = 'd2;
  localparam logic [BRAM_ADDR_W-1:0] ADDR_RA_HI  = 'd3;

  typedef logic [47:0] mac_addr_t;
  typedef logic [15:0] dur_t;
  typedef logic [3:0]  retr_cnt_t;
  typedef logic [14:0] tmr_t;

  typedef enum logic [2:0] {
    IDLE,
    SEND_ACK,
    SEND_ACK_DO,
    RECV_ACK_JUDGE,
    RECV_ACK_WAIT_TX_BB_DONE,
    RECV_ACK_WAIT_SIG_VALID,
    RECV_ACK,
    RECV_ACK_WAIT_BACKOFF_DONE
  } ctrl_state_t;

  // one reply word, read either as phy signal field or as mac header
  typedef union packed {
    struct packed {
      logic [31:0] zero_hi;
      logic [13:0] zero_mid;
      logic        parity;
      logic [11:0] len;
      logic        zero_lo;
      logic [3:0]  rate;
    } sig;
    struct packed {
      logic [31:0] addr;
      dur_t        dur;
      logic [7:0]  zero_hi;
      logic [3:0]  subtype;
      logic [1:0]  ftype;
      logic [1:0]  zero_lo;
    } hdr;
  } resp_word_u;

endpackage

// File: src/frame_classifier.sv
// frame classifier, decodes rx frame control and address match, holds the reply context
`timescale 1ns/1ns

module frame_classifier import tx_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        capture,
  input  logic        fcs_valid,
  input  logic        sig_valid,
  input  logic [15:0] signal_len,
  input  logic [1:0]  fc_type,
  input  logic [3:0]  fc_subtype,
  input  logic        fc_more_frag,
  input  logic        cts_torts_disable,
  input  dur_t        duration,
  input  mac_addr_t   addr1,
  input  mac_addr_t   addr2,
  input  mac_addr_t   self_mac_addr,
  output logic        resp_needed,
  output logic        ack_sig_seen,
  output logic        ack_frame_seen,
  output logic [1:0]  rx_class,
  output dur_t        rx_duration,
  output mac_addr_t   rx_addr2
);

  logic is_ctrl, is_data, is_mgmt, is_bar, is_ba, is_pspoll, is_rts;
  logic for_us;
  logic ack_owed;

  assign for_us    = (addr1 == self_mac_addr);
  assign is_ctrl   = (fc_type == FC_TYPE_CTRL);
  assign is_data   = (fc_type == FC_TYPE_DATA);
  assign is_mgmt   = (fc_type == FC_TYPE_MGMT) && (fc_subtype != FC_SUB_MGMT_EXCL);
  assign is_bar    = is_ctrl && (fc_subtype == FC_SUB_BAR);
  assign is_ba     = is_ctrl && (fc_subtype == FC_SUB_BA);
  assign is_pspoll = is_ctrl && (fc_subtype == FC_SUB_PSPOLL);
  // only a well formed rts, length 20
  assign is_rts    = is_ctrl && (fc_subtype == FC_SUB_RTS) && (signal_len == RTS_SIG_LEN);

  // frames answered with an ack
  assign ack_owed = is_data || is_mgmt || is_bar || is_ba || is_pspoll;

  assign resp_needed = fcs_valid && for_us && (ack_owed || (is_rts && !cts_torts_disable));
  // peer ack signal field, 14 bytes
  assign ack_sig_seen   = sig_valid && (signal_len == 16'(ACK_SIG_LEN));
  assign ack_frame_seen = fcs_valid && for_us && is_ctrl && (fc_subtype == FC_SUB_ACK);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_class <= CLS_NONE;
    end else if (capture) begin
      // last fragment of data/mgmt gets a zero duration ack
      if ((is_data || is_mgmt) && !fc_more_frag) begin
        rx_class <= CLS_ACK_ZERO;
      end else if (ack_owed) begin
        rx_class <= CLS_ACK_DUR;
      end else if (is_rts) begin
        rx_class <= CLS_CTS;
      end else begin
        rx_class <= CLS_NONE;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (capture) begin
      rx_duration <= duration;
      // reply ra is the sender
      rx_addr2    <= addr2;
    end
  end

endmodule

// File: src/ack_ctrl_fsm.sv
// ack control FSM, sequences the reply transmission and the wait for the peer ack
`timescale 1ns/1ns

module ack_ctrl_fsm import tx_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  logic        resp_needed,
  input  logic        ack_sig_seen,
  input  logic        ack_frame_seen,
  input  logic        wait_done,
  input  logic        sig_timeout,
  input  logic        ack_timeout,
  input  logic        phy_tx_done,
  input  logic        pulse_tx_bb_end,
  input  logic        tx_pkt_need_ack,
  input  logic        backoff_done,
  input  logic        quit_retrans,
  input  logic        retrans_in_progress,
  output ctrl_state_t state,
  output logic        start_tx_ack,
  output logic        start_retrans,
  output logic        ack_tx_flag,
  output logic        ack_cts_is_ongoing,
  output logic        tx_control_state_idle,
  output logic        done_ok,
  output logic        done_fail,
  output logic        retry,
  output logic        quit
);

  logic retrans_started;
  logic in_idle;
  logic in_backoff;

  assign in_idle    = (state == IDLE);
  assign in_backoff = (state == RECV_ACK_WAIT_BACKOFF_DONE);

  // wait plus the reply on air
  assign ack_cts_is_ongoing = (state == SEND_ACK) || (state == SEND_ACK_DO);
  // busy again once a retransmission has been kicked off
  assign tx_control_state_idle = (in_idle || in_backoff) && !retrans_started;

  // tracker events
  // attempt sent, not acknowledged so far
  assign done_fail = (state == RECV_ACK_JUDGE);
  // timeout wins over a late ack
  assign done_ok = (state == RECV_ACK) && !ack_timeout && ack_frame_seen;
  assign retry   = sig_timeout || ack_timeout;
  // idle gives priority to a reply and to our own tx end
  assign quit = quit_retrans && (in_backoff ||
                (in_idle && !resp_needed && !phy_tx_done && retrans_in_progress));

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state           <= IDLE;
      start_tx_ack    <= 1'b0;
      start_retrans   <= 1'b0;
      ack_tx_flag     <= 1'b0;
      retrans_started <= 1'b0;
    end else begin
      // one-cycle strobes
      start_tx_ack  <= 1'b0;
      start_retrans <= 1'b0;
      case (state)
        IDLE: begin
          ack_tx_flag <= 1'b0;
          if (resp_needed) begin
            state <= SEND_ACK;
          end else if (phy_tx_done) begin
            // a reply never returns here before its own phy_tx_done
            state <= RECV_ACK_JUDGE;
          end else if (quit) begin
            retrans_started <= 1'b0;
          end else if (backoff_done && retrans_in_progress) begin
            state <= RECV_ACK_WAIT_BACKOFF_DONE;
          end
        end
        SEND_ACK: begin
          ack_tx_flag <= 1'b1;
          if (wait_done) begin
            state        <= SEND_ACK_DO;
            start_tx_ack <= 1'b1;
          end
        end
        SEND_ACK_DO: begin
          if (phy_tx_done) begin
            state <= IDLE;
          end
        end
        RECV_ACK_JUDGE: begin
          retrans_started <= 1'b0;
          state <= tx_pkt_need_ack ? RECV_ACK_WAIT_TX_BB_DONE : IDLE;
        end
        RECV_ACK_WAIT_TX_BB_DONE: begin
          if (pulse_tx_bb_end) begin
            state <= RECV_ACK_WAIT_SIG_VALID;
          end
        end
        RECV_ACK_WAIT_SIG_VALID: begin
          if (sig_timeout) begin
            state <= IDLE;
          end else if (ack_sig_seen) begin
            state <= RECV_ACK;
          end
        end
        RECV_ACK: begin
          if (ack_timeout || ack_frame_seen) begin
            state <= IDLE;
          end
        end
        RECV_ACK_WAIT_BACKOFF_DONE: begin
          state <= IDLE;
          if (quit) begin
            retrans_started <= 1'b0;
          end else begin
            start_retrans   <= 1'b1;
            retrans_started <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  // reply and retransmission share the phy, never both at once
  assert property (@(posedge clk) disable iff (!rstn) !(start_tx_ack && start_retrans));

endmodule

// File: src/ack_frame_builder.sv
// reply builder that works out the ack/cts duration and serves the reply words to the phy
`timescale 1ns/1ns

module ack_frame_builder import tx_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  ctrl_state_t            state,
  input  logic [1:0]             rx_class,
  input  dur_t                   rx_duration,
  input  mac_addr_t              rx_addr2,
  input  dur_t                   duration_extra,
  input  logic [6:0]             preamble_sig_time,
  input  logic [4:0]             ofdm_symbol_time,
  input  logic [6:0]             sifs_time,
  input  logic [BRAM_ADDR_W-1:0] bram_addr,
  output logic [63:0]            dina
);

  dur_t       ackcts_time;
  dur_t       sifs_reg;
  dur_t       resp_dur;
  logic [3:0] resp_sub;
  resp_word_u sig_word;
  resp_word_u hdr_word;
  resp_word_u ra_hi_word;

  // airtime of our own ack/cts as preamble plus 6 symbols
  always_ff @(posedge clk) begin
    ackcts_time <= dur_t'(preamble_sig_time) + dur_t'(ACK_N_SYM) * dur_t'(ofdm_symbol_time);
    sifs_reg    <= dur_t'(sifs_time);
  end

  always_ff @(posedge clk) begin
    if (state == SEND_ACK) begin
      resp_sub <= (rx_class == CLS_CTS) ? FC_SUB_CTS : FC_SUB_ACK;
      if (rx_class == CLS_ACK_ZERO || rx_duration == '0) begin
        // zero received duration would underflow
        resp_dur <= duration_extra;
      end else begin
        // remaining nav minus our reply and one sifs
        resp_dur <= duration_extra + rx_duration - ackcts_time - sifs_reg;
      end
    end
  end

  always_comb begin
    sig_word            = '0;
    sig_word.sig.parity = ~(^RATE_6M);
    sig_word.sig.len    = ACK_SIG_LEN;
    sig_word.sig.rate   = RATE_6M;
    hdr_word             = '0;
    hdr_word.hdr.addr    = rx_addr2[31:0];
    hdr_word.hdr.dur     = resp_dur;
    hdr_word.hdr.subtype = resp_sub;
    // ack and cts are both control frames
    hdr_word.hdr.ftype   = FC_TYPE_CTRL;
    // ra high half sits in the low bits of word 3
    ra_hi_word = resp_word_u'({48'd0, rx_addr2[47:32]});
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      dina <= '0;
    end else if (state == SEND_ACK_DO) begin
      case (bram_addr)
        ADDR_SIG:   dina <= sig_word;
        ADDR_HDR:   dina <= hdr_word;
        ADDR_RA_HI: dina <= ra_hi_word;
        default:    dina <= dina;
      endcase
    end
  end

  // word 1 is not part of the reply
  assert property (@(posedge clk) disable iff (!rstn)
    (bram_addr == BRAM_ADDR_W'(1)) |=> $stable(dina));

endmodule

// File: src/ack_timer.sv
// ack timer, one counter for the reply wait and both ack receive timeouts
`timescale 1ns/1ns

module ack_timer import tx_ctrl_pkg::*; (
  input  logic        clk,
  input  logic        rstn,
  input  ctrl_state_t state,
  input  logic        ack_sig_seen,
  input  tmr_t        send_ack_wait_top,
  input  tmr_t        recv_ack_sig_valid_timeout_top,
  input  tmr_t        recv_ack_timeout_top_adj,
  output logic        wait_done,
  output logic        sig_timeout,
  output logic        ack_timeout
);

  tmr_t cnt;
  tmr_t send_scale;
  tmr_t sig_scale;
  tmr_t ack_top;

  // tops come in units of COUNT_SCALE clocks
  always_ff @(posedge clk) begin
    send_scale <= tmr_t'(send_ack_wait_top * COUNT_SCALE);
    sig_scale  <= tmr_t'(recv_ack_sig_valid_timeout_top * COUNT_SCALE);
    // peer ack body, 6 symbols of 4 us, plus the adjust
    ack_top    <= tmr_t'(ACK_N_SYM * 4 * NUM_CLK_PER_US + recv_ack_timeout_top_adj * COUNT_SCALE);
  end

  assign wait_done   = (state == SEND_ACK) && (cnt == send_scale);
  assign sig_timeout = (state == RECV_ACK_WAIT_SIG_VALID) && (cnt == sig_scale);
  assign ack_timeout = (state == RECV_ACK) && (cnt == ack_top);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      cnt <= '0;
    end else begin
      case (state)
        IDLE: cnt <= '0;
        // stops at the top
        SEND_ACK: begin
          if (!wait_done) begin
            cnt <= cnt + 1'b1;
          end
        end
        // ack frame window restarts at the signal field
        RECV_ACK_WAIT_SIG_VALID: cnt <= ack_sig_seen ? '0 : cnt + 1'b1;
        RECV_ACK: cnt <= cnt + 1'b1;
        default: cnt <= cnt;
      endcase
    end
  end

endmodule

// File: src/retrans_tracker.sv
// retry tracker, counts retransmissions against the limit and locks the tx status
`timescale 1ns/1ns

module retrans_tracker import tx_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       done_ok,
  input  logic       done_fail,
  input  logic       retry,
  input  logic       quit,
  input  retr_cnt_t  max_num_retrans,
  input  retr_cnt_t  tx_pkt_retrans_limit,
  input  logic       tx_pkt_need_ack,
  output logic       retrans_in_progress,
  output logic       tx_try_complete,
  output logic [4:0] tx_status
);

  retr_cnt_t num_retrans;
  retr_cnt_t cnt_lock;
  retr_cnt_t retrans_limit;
  logic      fail_lock;

  // global setting overrides the per packet limit
  assign retrans_limit = (max_num_retrans != '0) ? max_num_retrans : tx_pkt_retrans_limit;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      num_retrans         <= '0;
      cnt_lock            <= '0;
      fail_lock           <= 1'b0;
      retrans_in_progress <= 1'b0;
      tx_try_complete     <= 1'b0;
      tx_status           <= '0;
    end else begin
      tx_try_complete <= 1'b0;
      // status trails the complete pulse by one cycle
      tx_status <= {fail_lock, cnt_lock};
      if (quit || done_ok || (done_fail && !tx_pkt_need_ack) ||
          (retry && (num_retrans == retrans_limit || retrans_limit == '0))) begin
        // attempt over, lock result and rearm
        tx_try_complete     <= 1'b1;
        fail_lock           <= quit || retry;
        cnt_lock            <= num_retrans;
        num_retrans         <= '0;
        retrans_in_progress <= 1'b0;
      end else if (done_fail) begin
        retrans_in_progress <= 1'b1;
      end else if (retry) begin
        num_retrans <= num_retrans + 1'b1;
      end
    end
  end

  // one interrupt per attempt
  assert property (@(posedge clk) disable iff (!rstn) tx_try_complete |=> !tx_try_complete);

endmodule

// File: src/tx_control.sv
// tx control top, ack/cts reply and ack wait with retransmission for the 802.11 mac
`timescale 1ns/1ns

module tx_control import tx_ctrl_pkg::*; (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic [6:0]             preamble_sig_time,
  input  logic [4:0]             ofdm_symbol_time,
  input  logic [6:0]             sifs_time,
  input  retr_cnt_t              max_num_retrans,
  input  logic                   tx_pkt_need_ack,
  input  retr_cnt_t              tx_pkt_retrans_limit,
  input  tmr_t                   send_ack_wait_top,
  input  tmr_t                   recv_ack_timeout_top_adj,
  input  tmr_t                   recv_ack_sig_valid_timeout_top,
  input  logic                   pulse_tx_bb_end,
  input  logic                   phy_tx_done,
  input  logic                   sig_valid,
  input  logic [15:0]            signal_len,
  input  logic                   fcs_valid,
  input  logic [1:0]             fc_type,
  input  logic [3:0]             fc_subtype,
  input  logic                   fc_more_frag,
  input  logic                   cts_torts_disable,
  input  dur_t                   duration_extra,
  input  dur_t                   duration,
  input  mac_addr_t              addr1,
  input  mac_addr_t              addr2,
  input  mac_addr_t              self_mac_addr,
  input  logic                   backoff_done,
  input  logic                   quit_retrans,
  input  logic [BRAM_ADDR_W-1:0] bram_addr,
  output logic                   tx_control_state_idle,
  output logic                   ack_cts_is_ongoing,
  output logic                   retrans_in_progress,
  output logic                   start_retrans,
  output logic                   start_tx_ack,
  output logic                   tx_try_complete,
  output logic [4:0]             tx_status,
  output logic                   ack_tx_flag,
  output logic [63:0]            dina
);

  ctrl_state_t state;
  logic        capture;
  logic        resp_needed;
  logic        ack_sig_seen;
  logic        ack_frame_seen;
  logic [1:0]  rx_class;
  dur_t        rx_duration;
  mac_addr_t   rx_addr2;
  logic        wait_done;
  logic        sig_timeout;
  logic        ack_timeout;
  logic        done_ok;
  logic        done_fail;
  logic        retry;
  logic        quit;

  // rx frame fields are sampled while the FSM sits idle
  assign capture = (state == IDLE);

  frame_classifier u_classifier (
    .clk(clk), .rstn(rstn), .capture(capture),
    .fcs_valid(fcs_valid), .sig_valid(sig_valid), .signal_len(signal_len),
    .fc_type(fc_type), .fc_subtype(fc_subtype), .fc_more_frag(fc_more_frag),
    .cts_torts_disable(cts_torts_disable), .duration(duration),
    .addr1(addr1), .addr2(addr2), .self_mac_addr(self_mac_addr),
    .resp_needed(resp_needed), .ack_sig_seen(ack_sig_seen),
    .ack_frame_seen(ack_frame_seen), .rx_class(rx_class),
    .rx_duration(rx_duration), .rx_addr2(rx_addr2)
  );

  ack_ctrl_fsm u_fsm (
    .clk(clk), .rstn(rstn), .resp_needed(resp_needed),
    .ack_sig_seen(ack_sig_seen), .ack_frame_seen(ack_frame_seen),
    .wait_done(wait_done), .sig_timeout(sig_timeout), .ack_timeout(ack_timeout),
    .phy_tx_done(phy_tx_done), .pulse_tx_bb_end(pulse_tx_bb_end),
    .tx_pkt_need_ack(tx_pkt_need_ack), .backoff_done(backoff_done),
    .quit_retrans(quit_retrans), .retrans_in_progress(retrans_in_progress),
    .state(state), .start_tx_ack(start_tx_ack), .start_retrans(start_retrans),
    .ack_tx_flag(ack_tx_flag), .ack_cts_is_ongoing(ack_cts_is_ongoing),
    .tx_control_state_idle(tx_control_state_idle),
    .done_ok(done_ok), .done_fail(done_fail), .retry(retry), .quit(quit)
  );

  ack_frame_builder u_builder (
    .clk(clk), .rstn(rstn), .state(state), .rx_class(rx_class),
    .rx_duration(rx_duration), .rx_addr2(rx_addr2),
    .duration_extra(duration_extra), .preamble_sig_time(preamble_sig_time),
    .ofdm_symbol_time(ofdm_symbol_time), .sifs_time(sifs_time),
    .bram_addr(bram_addr), .dina(dina)
  );

  ack_timer u_timer (
    .clk(clk), .rstn(rstn), .state(state), .ack_sig_seen(ack_sig_seen),
    .send_ack_wait_top(send_ack_wait_top),
    .recv_ack_sig_valid_timeout_top(recv_ack_sig_valid_timeout_top),
    .recv_ack_timeout_top_adj(recv_ack_timeout_top_adj),
    .wait_done(wait_done), .sig_timeout(sig_timeout), .ack_timeout(ack_timeout)
  );

  retrans_tracker u_tracker (
    .clk(clk), .rstn(rstn), .done_ok(done_ok), .done_fail(done_fail),
    .retry(retry), .quit(quit), .max_num_retrans(max_num_retrans),
    .tx_pkt_retrans_limit(tx_pkt_retrans_limit), .tx_pkt_need_ack(tx_pkt_need_ack),
    .retrans_in_progress(retrans_in_progress), .tx_try_complete(tx_try_complete),
    .tx_status(tx_status)
  );

endmodule

// File: verification/tb_clock_gen.sv
// testbench clock and reset source, 100 ns clock and a 3 cycle active low reset
`timescale 1ns/1ns

module tb_clock_gen (
  output logic clk,
  output logic rstn
);

  // 100 ns period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // held low over three rising edges, released away from the edge
  initial begin
    rstn = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rstn = 1'b1;
  end

endmodule

// File: verification/tb_tx_control.sv
// tx control testbench that checks random reply and ack wait traffic against a reference model
`timescale 1ns/1ns

module tb_tx_control import tx_ctrl_pkg::*; ();

  localparam int CLK_PERIOD = 100;
  localparam int SIG_TOP    = 20;
  localparam int ADJ_MAX    = 3;
  localparam int WAIT_MAX   = 4;
  // longest window is the ack frame window with the largest adjust
  localparam int ACK_WIN    = ACK_N_SYM * 4 * NUM_CLK_PER_US + ADJ_MAX * COUNT_SCALE;
  localparam int SIG_WIN    = SIG_TOP * COUNT_SCALE;
  localparam int LONG_WIN   = (ACK_WIN > SIG_WIN) ? ACK_WIN : SIG_WIN;
  localparam int WAIT_LIMIT = LONG_WIN + 20;
  localparam int N_STEPS    = 16;
  localparam int MARGIN     = 40;

  // pulse and wait selectors
  localparam int P_PHY_DONE = 0;
  localparam int P_BB_END   = 1;
  localparam int P_SIG      = 2;
  localparam int P_BACKOFF  = 3;
  localparam int P_QUIT     = 4;
  localparam int O_TX_ACK   = 0;
  localparam int O_RETRANS  = 1;
  localparam int O_COMPLETE = 2;
  localparam int O_IDLE     = 3;

  logic clk, rstn;
  logic [6:0] preamble_sig_time, sifs_time;
  logic [4:0] ofdm_symbol_time;
  retr_cnt_t max_num_retrans, tx_pkt_retrans_limit;
  logic tx_pkt_need_ack, pulse_tx_bb_end, phy_tx_done, sig_valid, fcs_valid;
  tmr_t send_ack_wait_top, recv_ack_timeout_top_adj, recv_ack_sig_valid_timeout_top;
  logic [15:0] signal_len;
  logic [1:0] fc_type;
  logic [3:0] fc_subtype;
  logic fc_more_frag, cts_torts_disable, backoff_done, quit_retrans;
  dur_t duration_extra, duration;
  mac_addr_t addr1, addr2, self_mac_addr;
  logic [BRAM_ADDR_W-1:0] bram_addr;
  logic tx_control_state_idle, ack_cts_is_ongoing, retrans_in_progress;
  logic start_retrans, start_tx_ack, tx_try_complete, ack_tx_flag;
  logic [4:0] tx_status;
  logic [63:0] dina;

  logic [31:0] lcg_state;
  string test_name;
  int test_errs, n_pass, n_fail;

  tb_clock_gen u_clk_gen (.clk(clk), .rstn(rstn));

  tx_control uut (.*);

  // lcg step returning the slow upper half
  function automatic logic [15:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state[31:16];
  endfunction

  function automatic mac_addr_t rand_addr();
    return {next_rand(), next_rand(), next_rand()};
  endfunction

  // model of the phy signal field of a 14 byte reply at 6 Mb/s
  function automatic logic [63:0] model_sig_word();
    logic [3:0] rate;
    rate = 4'b1011;
    return {46'd0, ~(^rate), 12'd14, 1'b0, rate};
  endfunction

  // model of the reply duration rule
  function automatic dur_t model_dur(input bit zero_rule, input dur_t rx_dur);
    dur_t airtime;
    airtime = dur_t'(preamble_sig_time) + dur_t'(6) * dur_t'(ofdm_symbol_time);
    if (zero_rule || rx_dur == 16'd0) begin
      return duration_extra;
    end
    return duration_extra + rx_dur - airtime - dur_t'(sifs_time);
  endfunction

  function automatic logic [63:0] model_hdr_word(input mac_addr_t ra, input dur_t dur,
                                                 input logic [3:0] sub);
    return {ra[31:0], dur, 8'd0, sub, 2'b01, 2'b00};
  endfunction

  function automatic logic out_level(input int which);
    case (which)
      O_TX_ACK:   return start_tx_ack;
      O_RETRANS:  return start_retrans;
      O_COMPLETE: return tx_try_complete;
      default:    return tx_control_state_idle;
    endcase
  endfunction

  task automatic begin_test(input string name);
    test_name = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      $display("test %s: ok", test_name);
      n_pass++;
    end else begin
      $display("test %s: %0d errors", test_name, test_errs);
      n_fail++;
    end
  endtask

  task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      test_errs++;
    end
  endtask

  task automatic report_error(input string msg);
    $display("ERROR %s: %s", test_name, msg);
    test_errs++;
  endtask

  // one cycle strobe set and cleared on falling edges
  task automatic pulse_input(input int which);
    case (which)
      P_PHY_DONE: phy_tx_done = 1'b1;
      P_BB_END:   pulse_tx_bb_end = 1'b1;
      P_SIG: begin
        sig_valid  = 1'b1;
        signal_len = 16'd14;
      end
      P_BACKOFF:  backoff_done = 1'b1;
      default:    quit_retrans = 1'b1;
    endcase
    @(negedge clk);
    phy_tx_done     = 1'b0;
    pulse_tx_bb_end = 1'b0;
    sig_valid       = 1'b0;
    signal_len      = 16'd0;
    backoff_done    = 1'b0;
    quit_retrans    = 1'b0;
  endtask

  task automatic wait_for(input int which, input string what, output int cycles);
    cycles = 0;
    while (!out_level(which) && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!out_level(which)) begin
      report_error({"timed out waiting for ", what});
    end
  endtask

  task automatic send_frame(input logic [1:0] ftype, input logic [3:0] sub, input logic more,
                            input dur_t dur, input mac_addr_t a1, input mac_addr_t a2,
                            input logic [15:0] slen);
    fcs_valid    = 1'b1;
    fc_type      = ftype;
    fc_subtype   = sub;
    fc_more_frag = more;
    duration     = dur;
    addr1        = a1;
    addr2        = a2;
    signal_len   = slen;
    @(negedge clk);
    fcs_valid  = 1'b0;
    signal_len = 16'd0;
  endtask

  // addressed frame whose reply words are read back through the bram port
  task automatic run_reply(input logic [1:0] ftype, input logic [3:0] sub, input logic more,
                           input logic [15:0] slen);
    int wait_top, n;
    mac_addr_t ra;
    dur_t rx_dur;
    bit zero_rule, is_rts;
    logic [63:0] word3;
    wait_top = 1 + next_rand() % WAIT_MAX;
    send_ack_wait_top = tmr_t'(wait_top);
    @(negedge clk);
    ra = rand_addr();
    rx_dur = next_rand();
    is_rts = (ftype == FC_TYPE_CTRL) && (sub == FC_SUB_RTS);
    zero_rule = (ftype == FC_TYPE_DATA || ftype == FC_TYPE_MGMT) && !more;
    send_frame(ftype, sub, more, rx_dur, self_mac_addr, ra, slen);
    if (!ack_cts_is_ongoing) begin
      report_error("no reply started for an addressed frame");
    end
    wait_for(O_TX_ACK, "start_tx_ack", n);
    check_val("reply wait cycles", 4 * wait_top + 1, n);
    check_val("ack_tx_flag during reply", 1, ack_tx_flag);
    bram_addr = 'd0;
    @(negedge clk);
    check_val("start_tx_ack width", 0, start_tx_ack);
    check_val("word 0", model_sig_word(), dina);
    bram_addr = 'd2;
    @(negedge clk);
    check_val("word 2", model_hdr_word(ra, model_dur(zero_rule, rx_dur),
              is_rts ? FC_SUB_CTS : FC_SUB_ACK), dina);
    bram_addr = 'd3;
    @(negedge clk);
    word3 = {48'd0, ra[47:32]};
    check_val("word 3", word3, dina);
    // address 1 is not a reply word
    bram_addr = 'd1;
    pulse_input(P_PHY_DONE);
    check_val("word held on address 1", word3, dina);
    check_val("reply ongoing after phy done", 0, ack_cts_is_ongoing);
    check_val("idle after reply", 1, tx_control_state_idle);
  endtask

  task automatic no_reply(input logic [1:0] ftype, input logic [3:0] sub, input mac_addr_t a1,
                          input logic [15:0] slen);
    bit seen;
    seen = 1'b0;
    send_frame(ftype, sub, 1'b0, next_rand(), a1, rand_addr(), slen);
    repeat (4 * WAIT_MAX + 8) begin
      if (ack_cts_is_ongoing || start_tx_ack) begin
        seen = 1'b1;
      end
      @(negedge clk);
    end
    if (seen) begin
      report_error("reply sent for a frame that needs none");
    end
  endtask

  // own transmission end followed by the peer response
  // kind 0 is acked and kind 1 has no signal field
  // kind 2 has a signal field but no ack frame
  task automatic run_attempt(input int kind);
    pulse_input(P_PHY_DONE);
    repeat (1 + next_rand() % 2) @(negedge clk);
    pulse_input(P_BB_END);
    repeat (next_rand() % 3) @(negedge clk);
    if (kind != 1) begin
      pulse_input(P_SIG);
      if (kind == 0) begin
        send_frame(FC_TYPE_CTRL, FC_SUB_ACK, 1'b0, 16'd0, self_mac_addr, rand_addr(), 16'd0);
      end
    end
  endtask

  // failed attempt settles before a backoff and its retransmission
  task automatic retry_after_backoff();
    int n;
    wait_for(O_IDLE, "idle after timeout", n);
    if (tx_try_complete) begin
      report_error("attempt completed before the retry limit");
    end
    pulse_input(P_BACKOFF);
    wait_for(O_RETRANS, "start_retrans", n);
  endtask

  initial begin
    #(CLK_PERIOD * N_STEPS * (LONG_WIN + MARGIN));
    $display("watchdog: simulation ran past its time limit");
    $display("Regression failed");
    $finish;
  end

  initial begin
    int n, lim, q;
    lcg_state = 32'hbe5c;
    n_pass = 0;
    n_fail = 0;
    // 802.11a timing in us
    preamble_sig_time = 7'd20;
    ofdm_symbol_time = 5'd4;
    sifs_time = 7'd16;
    max_num_retrans = '0;
    tx_pkt_retrans_limit = '0;
    tx_pkt_need_ack = 1'b0;
    send_ack_wait_top = tmr_t'(1);
    recv_ack_sig_valid_timeout_top = tmr_t'(SIG_TOP);
    recv_ack_timeout_top_adj = tmr_t'(next_rand() % (ADJ_MAX + 1));
    pulse_tx_bb_end = 1'b0;
    phy_tx_done = 1'b0;
    sig_valid = 1'b0;
    signal_len = '0;
    fcs_valid = 1'b0;
    fc_type = '0;
    fc_subtype = '0;
    fc_more_frag = 1'b0;
    cts_torts_disable = 1'b0;
    duration_extra = dur_t'(next_rand() % 64);
    duration = '0;
    addr1 = '0;
    addr2 = '0;
    self_mac_addr = rand_addr();
    backoff_done = 1'b0;
    quit_retrans = 1'b0;
    bram_addr = 'd1;
    @(posedge rstn);
    @(negedge clk);

    begin_test("reset");
    check_val("start_tx_ack", 0, start_tx_ack);
    check_val("start_retrans", 0, start_retrans);
    check_val("tx_try_complete", 0, tx_try_complete);
    check_val("ack_tx_flag", 0, ack_tx_flag);
    check_val("retrans_in_progress", 0, retrans_in_progress);
    check_val("tx_status", 0, tx_status);
    check_val("tx_control_state_idle", 1, tx_control_state_idle);
    end_test();

    begin_test("ack reply");
    repeat (4) begin
      if (next_rand() % 2) begin
        run_reply(FC_TYPE_DATA, next_rand() % 16, next_rand() % 2, next_rand());
      end else begin
        // reserved mgmt subtype gets no ack
        q = next_rand() % 16;
        if (q == 14) begin
          q = 0;
        end
        run_reply(FC_TYPE_MGMT, q, next_rand() % 2, next_rand());
      end
    end
    end_test();

    begin_test("cts reply");
    run_reply(FC_TYPE_CTRL, FC_SUB_RTS, 1'b0, 16'd20);
    cts_torts_disable = 1'b1;
    no_reply(FC_TYPE_CTRL, FC_SUB_RTS, self_mac_addr, 16'd20);
    cts_torts_disable = 1'b0;
    no_reply(FC_TYPE_DATA, 4'd0, self_mac_addr ^ 48'h1, 16'd0);
    end_test();

    begin_test("no ack needed");
    tx_pkt_need_ack = 1'b0;
    pulse_input(P_PHY_DONE);
    wait_for(O_COMPLETE, "tx_try_complete", n);
    @(negedge clk);
    check_val("tx_status", 5'b0_0000, tx_status);
    end_test();

    begin_test("ack received");
    tx_pkt_need_ack = 1'b1;
    run_attempt(0);
    wait_for(O_COMPLETE, "tx_try_complete", n);
    @(negedge clk);
    check_val("tx_status", 5'b0_0000, tx_status);
    check_val("retrans_in_progress", 0, retrans_in_progress);
    end_test();

    begin_test("retry limit");
    lim = 1 + next_rand() % 3;
    max_num_retrans = '0;
    tx_pkt_retrans_limit = retr_cnt_t'(lim);
    for (int i = 0; i <= lim; i++) begin
      run_attempt(1 + next_rand() % 2);
      if (i < lim) begin
        retry_after_backoff();
      end else begin
        wait_for(O_COMPLETE, "tx_try_complete", n);
        @(negedge clk);
        check_val("tx_status", {1'b1, 4'(lim)}, tx_status);
      end
    end
    end_test();

    begin_test("quit");
    // global limit overrides a per packet limit that would end at the first retry
    max_num_retrans = retr_cnt_t'(4 + next_rand() % 3);
    tx_pkt_retrans_limit = '0;
    q = 1 + next_rand() % 2;
    for (int i = 0; i < q; i++) begin
      run_attempt(1 + next_rand() % 2);
      if (i < q - 1) begin
        retry_after_backoff();
      end else begin
        wait_for(O_IDLE, "idle after timeout", n);
      end
    end
    pulse_input(P_QUIT);
    wait_for(O_COMPLETE, "tx_try_complete", n);
    @(negedge clk);
    check_val("tx_status", {1'b1, 4'(q)}, tx_status);
    end_test();

    $display("tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
src/tx_ctrl_pkg.sv
src/frame_classifier.sv
src/ack_ctrl_fsm.sv
src/ack_frame_builder.sv
src/ack_timer.sv
src/retrans_tracker.sv
src/tx_control.sv
verification/tb_clock_gen.sv
verification/tb_tx_control.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_tx_control -f filelist.f
	./obj_dir/Vtb_tx_control | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
